/* addr_arb.f */
+incdir+src
src/addr_arb_pkg.sv
src/addr_class_decode.sv
src/rr_grant_select.sv
src/addr_arbiter.sv
src/addr_arb_top.sv
bench/addr_arb_tb.sv

/* bench/addr_arb_patterns.txt */
// Columns in hex: req addr0 addr1 addr2 addr3 exp_grant exp_idx exp_addr exp_hi
// One line per clock edge, results expected three edges later
// Idle line, pointer at 0
0 00000010 00000020 00000030 00000040 0 0 00000000 0
// Single requesters, each with its own index and address
1 00001000 00001100 00001200 00001300 1 0 00001000 0
4 00001000 00001100 00001200 00001300 4 2 00001200 0
8 00001000 00001100 00001200 00001300 8 3 00001300 0
2 00001000 00000090 00001200 00001300 2 1 00000090 1
// Idle, pointer holds at 2
0 00001000 00001100 00001200 00001300 0 0 00000000 0
// All four low, rotation starting at the held pointer
f 00001000 00001100 00001200 00001300 4 2 00001200 0
f 00001000 00001100 00001200 00001300 8 3 00001300 0
f 00001000 00001100 00001200 00001300 1 0 00001000 0
f 00001000 00001100 00001200 00001300 2 1 00001100 0
f 00001000 00001100 00001200 00001300 4 2 00001200 0
f 00001000 00001100 00001200 00001300 8 3 00001300 0
f 00001000 00001100 00001200 00001300 1 0 00001000 0
// High class at the lower bound beats three low requests
f 00000080 00001100 00001200 00001300 1 0 00000080 1
// Upper bound of the window
f 00001000 00001100 00001200 000000ff 8 3 000000ff 1
6 00001000 00001100 000000c0 00001300 4 2 000000c0 1
// Requester 2 is high but not requesting
b 00001000 000000a0 000000c0 00001300 2 1 000000a0 1
// Two high requesters alternate among low ones
f 00000088 00001100 00001200 000000f0 8 3 000000f0 1
f 00000088 00001100 00001200 000000f0 1 0 00000088 1
f 00000088 00001100 00001200 000000f0 8 3 000000f0 1
f 00000088 00001100 00001200 000000f0 1 0 00000088 1
f 00000088 00001100 00001200 000000f0 8 3 000000f0 1
// Just outside the window is low, back to back with changing requests
3 0000007f 00000100 00001200 00001300 1 0 0000007f 0
c 00001000 00001100 00000100 0000007f 4 2 00000100 0
5 00000100 00001100 0000007f 00001300 1 0 00000100 0
a 00001000 00000080 00001200 0000007f 2 1 00000080 1
f 0000007f 00000100 000000ff 00000080 4 2 000000ff 1
1 00000100 00001100 00001200 00001300 1 0 00000100 0
0 00001000 00001100 00001200 00001300 0 0 00000000 0
8 00001000 00001100 00001200 deadbeef 8 3 deadbeef 0
2 00001000 12345678 00001200 00001300 2 1 12345678 0
// Two idle lines, pointer stays at 2
0 00001000 00001100 00001200 00001300 0 0 00000000 0
0 00001000 00001100 00001200 00001300 0 0 00000000 0
// All four high
f 00000080 00000090 000000a0 000000b0 4 2 000000a0 1
f 00000080 00000090 000000a0 000000b0 8 3 000000b0 1
4 00001000 00001100 ffffffff 00001300 4 2 ffffffff 0
// Mixed bounds, only 0 and 3 are high
f 000000ff 0000007f 00000100 00000080 8 3 00000080 1
f 000000ff 0000007f 00000100 00000080 1 0 000000ff 1
// Address zero is below the window
6 00001000 00000000 00000000 00001300 2 1 00000000 0
0 00001000 00001100 00001200 00001300 0 0 00000000 0

/* bench/addr_arb_tb.sv */
// Address arbiter testbench with clock, reset, pattern vectors, delayed expectations and checks
`timescale 1ns/1ns
`default_nettype none

module addr_arb_tb;

    import addr_arb_pkg::*;

    // Hex words on one pattern line
    localparam int FIELDS     = 9;
    localparam int MAX_LINES  = 64;
    localparam int RST_CYCLES = 10;
    // Edges from a driven line to its result on the outputs
    localparam int LATENCY    = 3;
    localparam int SLACK      = 20;

    logic      clk;
    logic      rst;
    req_mask_t req;
    addr_bus_t addr;
    req_mask_t grant;
    logic      grant_valid;
    req_idx_t  grant_idx;
    addr_t     grant_addr;
    logic      grant_hi;

    // Raw pattern words, FIELDS per line
    logic [31:0] pat_mem [0:MAX_LINES*FIELDS-1];
    int          n_lines;
    int          cycle_count;
    int          cycle_limit;

    // Expected results on their way to the outputs, entry 0 newest
    req_mask_t exp_grant_d [0:LATENCY-1];
    req_idx_t  exp_idx_d   [0:LATENCY-1];
    addr_t     exp_addr_d  [0:LATENCY-1];
    logic      exp_hi_d    [0:LATENCY-1];

    addr_arb_top DUT (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .addr        (addr),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .grant_addr  (grant_addr),
        .grant_hi    (grant_hi)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle budget for the whole run
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_limit > 0 && cycle_count > cycle_limit) begin
                $display("Timeout: the run went past %0d clock cycles", cycle_limit);
                $display("Simulation finished: FAIL");
                $fatal(1, "cycle limit reached");
            end
        end
    end

    task automatic stop_on_failure(input string reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    // A single flag shown as a full mask
    function automatic req_mask_t spread_bit(input logic flag);
        spread_bit = flag ? '1 : '0;
    endfunction

    function automatic req_mask_t idx_to_onehot(input req_idx_t idx);
        idx_to_onehot = req_mask_t'(1) << idx;
    endfunction

    task automatic check_mask(
        input string     name,
        input req_mask_t expected,
        input req_mask_t actual
    );
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, expected, actual);
            stop_on_failure("mask output mismatch");
        end
    endtask

    task automatic check_addr(
        input string name,
        input addr_t expected,
        input addr_t actual
    );
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, expected, actual);
            stop_on_failure("address output mismatch");
        end
    endtask

    // All five outputs against one expected result
    task automatic check_outputs(
        input req_mask_t e_grant,
        input req_idx_t  e_idx,
        input addr_t     e_addr,
        input logic      e_hi
    );
        check_mask("grant", e_grant, grant);
        // Valid follows a non-zero grant
        check_mask("grant_valid", spread_bit(|e_grant), spread_bit(grant_valid));
        check_mask("grant_idx", idx_to_onehot(e_idx), idx_to_onehot(grant_idx));
        check_addr("grant_addr", e_addr, grant_addr);
        check_mask("grant_hi", spread_bit(e_hi), spread_bit(grant_hi));
    endtask

    initial begin
        req_mask_t o_grant;
        req_idx_t  o_idx;
        addr_t     o_addr;
        logic      o_hi;
        int        base;

        rst         = 1'b1;
        req         = '0;
        addr        = '0;
        cycle_limit = 0;
        n_lines     = 0;
        for (int s = 0; s < LATENCY; s++) begin
            exp_grant_d[s] = '0;
            exp_idx_d[s]   = '0;
            exp_addr_d[s]  = '0;
            exp_hi_d[s]    = 1'b0;
        end

        // Unloaded words end up above any 4-bit request mask
        for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
            pat_mem[i] = 32'hf000_0000 | i;
        end
        $readmemh("bench/addr_arb_patterns.txt", pat_mem);
        while (n_lines < MAX_LINES && pat_mem[n_lines*FIELDS][31:4] == '0) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            $display("No vectors could be read from the pattern file");
            stop_on_failure("empty pattern file");
        end
        cycle_limit = n_lines + RST_CYCLES + SLACK;

        // Outputs stay zero while reset is held
        repeat (RST_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check_outputs('0, '0, '0, 1'b0);
        end
        @(posedge clk);
        rst <= 1'b0;

        // One line per edge, then idle edges until the last result is out
        for (int c = 0; c < n_lines + LATENCY; c++) begin
            @(posedge clk);
            o_grant = exp_grant_d[LATENCY-1];
            o_idx   = exp_idx_d[LATENCY-1];
            o_addr  = exp_addr_d[LATENCY-1];
            o_hi    = exp_hi_d[LATENCY-1];
            for (int s = LATENCY - 1; s > 0; s--) begin
                exp_grant_d[s] = exp_grant_d[s-1];
                exp_idx_d[s]   = exp_idx_d[s-1];
                exp_addr_d[s]  = exp_addr_d[s-1];
                exp_hi_d[s]    = exp_hi_d[s-1];
            end
            if (c < n_lines) begin
                base = c * FIELDS;
                req  <= req_mask_t'(pat_mem[base]);
                // Requester 0 in the low bits
                addr <= {pat_mem[base+4], pat_mem[base+3], pat_mem[base+2], pat_mem[base+1]};
                exp_grant_d[0] = req_mask_t'(pat_mem[base+5]);
                exp_idx_d[0]   = req_idx_t'(pat_mem[base+6]);
                exp_addr_d[0]  = addr_t'(pat_mem[base+7]);
                exp_hi_d[0]    = pat_mem[base+8][0];
            end else begin
                req  <= '0;
                addr <= '0;
                exp_grant_d[0] = '0;
                exp_idx_d[0]   = '0;
                exp_addr_d[0]  = '0;
                exp_hi_d[0]    = 1'b0;
            end
            @(negedge clk);
            check_outputs(o_grant, o_idx, o_addr, o_hi);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src/addr_arb_top.sv */
// Address arbiter subsystem top level
`timescale 1ns/1ns
`default_nettype none

module addr_arb_top (
    input  logic                    clk,
    input  logic                    rst,
    input  addr_arb_pkg::req_mask_t req,
    input  addr_arb_pkg::addr_bus_t addr,
    output addr_arb_pkg::req_mask_t grant,
    output logic                    grant_valid,
    output addr_arb_pkg::req_idx_t  grant_idx,
    output addr_arb_pkg::addr_t     grant_addr,
    output logic                    grant_hi
);

    // Shared memory port arbiter, three cycles from request to grant
    addr_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .addr        (addr),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .grant_addr  (grant_addr),
        .grant_hi    (grant_hi)
    );

endmodule

`default_nettype wire

/* src/addr_arbiter.sv */
// Three-stage address arbiter pipeline around the class decoder and grant selector
`timescale 1ns/1ns
`default_nettype none

module addr_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  addr_arb_pkg::req_mask_t req,
    input  addr_arb_pkg::addr_bus_t addr,
    output addr_arb_pkg::req_mask_t grant,
    output logic                    grant_valid,
    output addr_arb_pkg::req_idx_t  grant_idx,
    output addr_arb_pkg::addr_t     grant_addr,
    output logic                    grant_hi
);

    import addr_arb_pkg::*;

    // Stage-1 raw inputs
    req_mask_t req_s1;
    addr_bus_t addr_s1;

    // Decoder outputs on the stage-1 bus
    addr_vec_t addr_vec_s1;
    req_mask_t hi_map_s1;

    // Stage-2 split and classified values
    req_mask_t req_s2;
    req_mask_t hi_map_s2;
    addr_vec_t addr_vec_s2;

    // Stage-1 request levels
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_s1 <= '0;
        end else begin
            req_s1 <= req;
        end
    end

    // Stage-1 address bus
    always_ff @(posedge clk) begin
        addr_s1 <= addr;
    end

    addr_class_decode u_decode (
        .addr_bus (addr_s1),
        .addr_vec (addr_vec_s1),
        .hi_map   (hi_map_s1)
    );

    // Stage-2 requests and class map
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_s2    <= '0;
            hi_map_s2 <= '0;
        end else begin
            req_s2    <= req_s1;
            hi_map_s2 <= hi_map_s1;
        end
    end

    // Stage-2 per-requester addresses
    always_ff @(posedge clk) begin
        addr_vec_s2 <= addr_vec_s1;
    end

    // Third edge lands in the selector's result registers
    rr_grant_select u_select (
        .clk         (clk),
        .rst         (rst),
        .req         (req_s2),
        .hi_map      (hi_map_s2),
        .addr_vec    (addr_vec_s2),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .grant_addr  (grant_addr),
        .grant_hi    (grant_hi)
    );

endmodule

`default_nettype wire

/* src/rr_grant_select.sv */
// Round-robin grant selector with high-class masking and registered results
`timescale 1ns/1ns
`default_nettype none

`include "addr_arb_consts.svh"

module rr_grant_select (
    input  logic                    clk,
    input  logic                    rst,
    input  addr_arb_pkg::req_mask_t req,
    input  addr_arb_pkg::req_mask_t hi_map,
    input  addr_arb_pkg::addr_vec_t addr_vec,
    output addr_arb_pkg::req_mask_t grant,
    output logic                    grant_valid,
    output addr_arb_pkg::req_idx_t  grant_idx,
    output addr_arb_pkg::addr_t     grant_addr,
    output logic                    grant_hi
);

    import addr_arb_pkg::*;

    localparam int NREQ = `ADDR_ARB_NREQ;

    // Search start, one past the last winner
    req_idx_t  ptr;

    req_mask_t hi_req;
    req_mask_t cand;
    logic      found;
    req_idx_t  win_idx;
    req_mask_t win_onehot;

    // Only high-class requests compete when any is present
    assign hi_req = req & hi_map;
    assign cand   = (|hi_req) ? hi_req : req;

    // First candidate upward from the pointer, wrapping
    always_comb begin
        int unsigned pos;

        found   = 1'b0;
        win_idx = '0;
        for (int i = 0; i < NREQ; i++) begin
            pos = (int'(ptr) + i) % NREQ;
            if (!found && cand[pos]) begin
                found   = 1'b1;
                win_idx = req_idx_t'(pos);
            end
        end
    end

    assign win_onehot = found ? (req_mask_t'(1) << win_idx) : '0;

    // Result registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_idx   <= '0;
            grant_addr  <= '0;
            grant_hi    <= 1'b0;
        end else begin
            grant       <= win_onehot;
            grant_valid <= found;
            grant_idx   <= win_idx;
            grant_addr  <= found ? addr_vec[win_idx] : '0;
            grant_hi    <= found & hi_map[win_idx];
        end
    end

    // Pointer moves past the winner, holds on an idle cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= req_idx_t'((int'(win_idx) + 1) % NREQ);
        end
    end

endmodule

`default_nettype wire

/* src/addr_class_decode.sv */
// Address bus splitter and high-priority window classifier
`timescale 1ns/1ns
`default_nettype none

`include "addr_arb_consts.svh"

module addr_class_decode (
    input  addr_arb_pkg::addr_bus_t addr_bus,
    output addr_arb_pkg::addr_vec_t addr_vec,
    output addr_arb_pkg::req_mask_t hi_map
);

    import addr_arb_pkg::*;

    localparam int AW   = `ADDR_ARB_AW;
    localparam int NREQ = `ADDR_ARB_NREQ;

    // Window bounds in the address type
    localparam addr_t HI_BASE  = `ADDR_ARB_HI_BASE;
    localparam addr_t HI_LIMIT = `ADDR_ARB_HI_LIMIT;

    genvar g;

    generate
        for (g = 0; g < NREQ; g++) begin : g_req
            // Requester g sits at bits g*AW and up
            assign addr_vec[g] = addr_bus[g*AW +: AW];

            // High class when inside the window, bounds included
            assign hi_map[g] = (addr_vec[g] >= HI_BASE) &&
                               (addr_vec[g] <= HI_LIMIT);
        end
    endgenerate

endmodule

`default_nettype wire

/* src/addr_arb_pkg.sv */
// Address arbiter package with address, mask, index and address-vector types
`default_nettype none

`include "addr_arb_consts.svh"

package addr_arb_pkg;

    // One requester address
    typedef logic [`ADDR_ARB_AW-1:0] addr_t;

    // One bit per requester, used for requests, class maps and grants
    typedef logic [`ADDR_ARB_NREQ-1:0] req_mask_t;

    // Requester index
    typedef logic [$clog2(`ADDR_ARB_NREQ)-1:0] req_idx_t;

    // All addresses packed side by side, requester 0 in the low bits
    typedef logic [`ADDR_ARB_NREQ*`ADDR_ARB_AW-1:0] addr_bus_t;

    // Addresses split out per requester
    typedef addr_t addr_vec_t [`ADDR_ARB_NREQ];

endpackage

`default_nettype wire

/* src/addr_arb_consts.svh */
// Address arbiter constants for address width, requester count and priority window
`ifndef ADDR_ARB_CONSTS_SVH
`define ADDR_ARB_CONSTS_SVH

// Width of one requester address
`define ADDR_ARB_AW 32

// Requesters sharing the memory port
`define ADDR_ARB_NREQ 4

// High-priority window, both bounds inclusive
`define ADDR_ARB_HI_BASE 32'h0000_0080
`define ADDR_ARB_HI_LIMIT 32'h0000_00FF

`endif
